/* verilog/apb_bridge_pkg.sv */
// Shared widths, bus encodings, FSM states and handshake payloads of the AHB to APB bridge
package apb_bridge_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////

  // AHB side
  localparam int HADDR_W = 32;
  localparam int HDATA_W = 32;

  // APB side, one byte lane per beat
  localparam int PDATA_W = 8;
  localparam int PSTRB_W = PDATA_W / 8;

  //////////////////////////////////////////////////////////////////////
  // AHB encodings
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  // Only sizes up to a word
  typedef enum logic [2:0] {
    HSIZE_BYTE  = 3'b000,
    HSIZE_HWORD = 3'b001,
    HSIZE_WORD  = 3'b010
  } hsize_e;

  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  //////////////////////////////////////////////////////////////////////
  // Handshake payloads
  //////////////////////////////////////////////////////////////////////

  // One AHB transfer, address and data phase merged
  typedef struct packed {
    logic [HADDR_W-1:0] addr;
    logic               write;
    hsize_e             size;
    // HPROT[1] privileged, HPROT[0] data
    logic [1:0]         hprot;
    logic [HDATA_W-1:0] wdata;
  } ahb_req_t;

  // One APB beat as it goes onto the pins
  typedef struct packed {
    logic [HADDR_W-1:0] addr;
    logic               write;
    logic [2:0]         pprot;
    logic [PDATA_W-1:0] pwdata;
    logic [PSTRB_W-1:0] pstrb;
  } apb_beat_t;

  typedef struct packed {
    logic [PDATA_W-1:0] prdata;
    logic               pslverr;
  } beat_result_t;

  typedef struct packed {
    logic [HDATA_W-1:0] hrdata;
    logic               error;
  } ahb_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // FSM states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {AHB_IDLE, AHB_WAIT, AHB_ERROR} ahb_state_e;
  typedef enum logic [1:0] {SEQ_IDLE, SEQ_ISSUE, SEQ_WAIT, SEQ_RESPOND} seq_state_e;
  typedef enum logic [1:0] {APB_IDLE, APB_SETUP, APB_ACCESS} apb_state_e;

endpackage

/* verilog/ahb_slave_port.sv */
// AHB3-Lite slave side of the bridge: address/data phase capture, wait states and response
`timescale 1ns/1ns

module ahb_slave_port (
  input  logic                                  HCLK,
  input  logic                                  HRESETn,
  // AHB slave pins
  input  logic                                  HSEL,
  input  logic [apb_bridge_pkg::HADDR_W-1:0]    HADDR,
  input  logic                                  HWRITE,
  input  logic [2:0]                            HSIZE,
  input  logic [1:0]                            HTRANS,
  input  logic [3:0]                            HPROT,
  input  logic                                  HREADY,
  input  logic [apb_bridge_pkg::HDATA_W-1:0]    HWDATA,
  output logic                                  HREADYOUT,
  output logic                                  HRESP,
  output logic [apb_bridge_pkg::HDATA_W-1:0]    HRDATA,
  // Transfer towards the sequencer
  output apb_bridge_pkg::ahb_req_t              req,
  output logic                                  req_valid,
  input  logic                                  req_ready,
  // Transfer result back from the sequencer
  input  apb_bridge_pkg::ahb_rsp_t              rsp,
  input  logic                                  rsp_valid
);

  apb_bridge_pkg::ahb_state_e state;
  apb_bridge_pkg::htrans_e    htrans;

  // High in the first data-phase cycle, when HWDATA is valid
  logic data_phase;
  logic accept;

  assign htrans = apb_bridge_pkg::htrans_e'(HTRANS);

  // IDLE and BUSY fall through and get a zero-wait OKAY
  assign accept = (state == apb_bridge_pkg::AHB_IDLE) && HSEL && HREADY &&
                  ((htrans == apb_bridge_pkg::HTRANS_NONSEQ) ||
                   (htrans == apb_bridge_pkg::HTRANS_SEQ));

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state      <= apb_bridge_pkg::AHB_IDLE;
      HREADYOUT  <= 1'b1;
      HRESP      <= apb_bridge_pkg::HRESP_OKAY;
      data_phase <= 1'b0;
      req_valid  <= 1'b0;
    end
    else
    begin
      data_phase <= 1'b0;

      // Offer the request once the write data is in
      if (data_phase)
        req_valid <= 1'b1;
      else if (req_valid && req_ready)
        req_valid <= 1'b0;

      case (state)
        apb_bridge_pkg::AHB_IDLE:
        begin
          // Also closes the second error cycle
          HRESP     <= apb_bridge_pkg::HRESP_OKAY;
          HREADYOUT <= !accept;
          if (accept)
          begin
            state      <= apb_bridge_pkg::AHB_WAIT;
            data_phase <= 1'b1;
          end
        end

        apb_bridge_pkg::AHB_WAIT:
        begin
          // Master held in wait states until the sequencer answers
          if (rsp_valid)
          begin
            if (rsp.error)
            begin
              // First error cycle, HREADYOUT still low
              HRESP <= apb_bridge_pkg::HRESP_ERROR;
              state <= apb_bridge_pkg::AHB_ERROR;
            end
            else
            begin
              HREADYOUT <= 1'b1;
              state     <= apb_bridge_pkg::AHB_IDLE;
            end
          end
        end

        apb_bridge_pkg::AHB_ERROR:
        begin
          // Second error cycle
          HREADYOUT <= 1'b1;
          state     <= apb_bridge_pkg::AHB_IDLE;
        end

        default:
          state <= apb_bridge_pkg::AHB_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Address, data and read data registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK)
  begin
    if (accept)
    begin
      req.addr  <= HADDR;
      req.write <= HWRITE;
      req.size  <= apb_bridge_pkg::hsize_e'(HSIZE);
      req.hprot <= HPROT[1:0];
    end
    if (data_phase)
      req.wdata <= HWDATA;
    if (rsp_valid)
      HRDATA <= rsp.hrdata;
  end

endmodule

/* verilog/beat_sequencer.sv */
// Splits one AHB transfer into APB beats and gathers the read bytes into HRDATA lanes
`timescale 1ns/1ns

module beat_sequencer (
  input  logic                          HCLK,
  input  logic                          HRESETn,
  // Transfer from the AHB port
  input  apb_bridge_pkg::ahb_req_t      req,
  input  logic                          req_valid,
  output logic                          req_ready,
  // Beats to the APB port
  output apb_bridge_pkg::apb_beat_t     beat,
  output logic                          beat_valid,
  input  logic                          beat_ready,
  // Beat results, always accepted
  input  apb_bridge_pkg::beat_result_t  result,
  input  logic                          result_valid,
  // Transfer result to the AHB port
  output apb_bridge_pkg::ahb_rsp_t      rsp,
  output logic                          rsp_valid
);

  // Bytes on the AHB data bus and beat counter width
  localparam int HBYTES = apb_bridge_pkg::HDATA_W / 8;
  localparam int OFF_W  = $clog2(HBYTES);
  localparam int CNT_W  = $clog2(HBYTES + 1);

  apb_bridge_pkg::seq_state_e state;
  apb_bridge_pkg::ahb_req_t   cur;

  logic [CNT_W-1:0]                   idx;
  logic [CNT_W-1:0]                   last;
  logic                               err;
  logic [apb_bridge_pkg::HDATA_W-1:0] rdata;
  logic [apb_bridge_pkg::HADDR_W-1:0] beat_addr;
  // Byte offset of the current beat inside HWDATA/HRDATA
  logic [OFF_W-1:0]                   lane_off;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Transfer size in bytes over APB width, never below one
  function automatic logic [CNT_W-1:0] beat_count(input apb_bridge_pkg::hsize_e size);
    int bytes;
    bytes = 1 << size;
    if (bytes <= apb_bridge_pkg::PSTRB_W)
      return CNT_W'(1);
    return CNT_W'(bytes / apb_bridge_pkg::PSTRB_W);
  endfunction

  // Write strobes for the lanes covered by the transfer
  function automatic logic [apb_bridge_pkg::PSTRB_W-1:0] lane_strobe(
    input apb_bridge_pkg::hsize_e           size,
    input logic [apb_bridge_pkg::HADDR_W-1:0] addr
  );
    int bytes;
    bytes = 1 << size;
    if (bytes >= apb_bridge_pkg::PSTRB_W)
      return '1;
    return apb_bridge_pkg::PSTRB_W'(((1 << bytes) - 1) << (addr % apb_bridge_pkg::PSTRB_W));
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Beat generation
  //////////////////////////////////////////////////////////////////////

  assign beat_addr = cur.addr + apb_bridge_pkg::HADDR_W'(idx * apb_bridge_pkg::PSTRB_W);
  // Aligned down to the APB data width
  assign lane_off  = beat_addr[OFF_W-1:0] & OFF_W'(~(apb_bridge_pkg::PSTRB_W - 1));

  always_comb
  begin
    beat.addr   = beat_addr;
    beat.write  = cur.write;
    // Privileged to bit 0, instruction to bit 2, always secure
    beat.pprot  = {~cur.hprot[0], 1'b0, cur.hprot[1]};
    beat.pwdata = cur.wdata[8*lane_off +: apb_bridge_pkg::PDATA_W];
    // Reads carry no strobes
    beat.pstrb  = cur.write ? lane_strobe(cur.size, beat_addr) : '0;
  end

  assign req_ready  = (state == apb_bridge_pkg::SEQ_IDLE);
  assign beat_valid = (state == apb_bridge_pkg::SEQ_ISSUE);
  assign rsp_valid  = (state == apb_bridge_pkg::SEQ_RESPOND);
  assign rsp        = '{hrdata: rdata, error: err};

  //////////////////////////////////////////////////////////////////////
  // Sequencer FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state <= apb_bridge_pkg::SEQ_IDLE;
      idx   <= '0;
      err   <= 1'b0;
    end
    else
    begin
      case (state)
        apb_bridge_pkg::SEQ_IDLE:
        begin
          if (req_valid)
          begin
            state <= apb_bridge_pkg::SEQ_ISSUE;
            idx   <= '0;
            err   <= 1'b0;
          end
        end

        apb_bridge_pkg::SEQ_ISSUE:
        begin
          if (beat_ready)
            state <= apb_bridge_pkg::SEQ_WAIT;
        end

        apb_bridge_pkg::SEQ_WAIT:
        begin
          if (result_valid)
          begin
            // Slave error cuts the transfer short
            if (result.pslverr || (idx == last))
            begin
              state <= apb_bridge_pkg::SEQ_RESPOND;
              err   <= result.pslverr;
            end
            else
            begin
              idx   <= idx + 1'b1;
              state <= apb_bridge_pkg::SEQ_ISSUE;
            end
          end
        end

        // AHB port is waiting, one cycle is enough
        apb_bridge_pkg::SEQ_RESPOND:
          state <= apb_bridge_pkg::SEQ_IDLE;

        default:
          state <= apb_bridge_pkg::SEQ_IDLE;
      endcase
    end
  end

  // Transfer copy and read data assembly
  always_ff @(posedge HCLK)
  begin
    if (req_valid && req_ready)
    begin
      cur   <= req;
      last  <= beat_count(req.size) - 1'b1;
      // Lanes that are never read return zero
      rdata <= '0;
    end
    else if ((state == apb_bridge_pkg::SEQ_WAIT) && result_valid)
      rdata[8*lane_off +: apb_bridge_pkg::PDATA_W] <= result.prdata;
  end

endmodule

/* verilog/apb_master_port.sv */
// APB4 master side of the bridge: one setup and one or more access cycles per beat
`timescale 1ns/1ns

module apb_master_port #(
  parameter int PADDR_WIDTH = 10
)
(
  input  logic                                  HCLK,
  input  logic                                  HRESETn,
  // Beat from the sequencer
  input  apb_bridge_pkg::apb_beat_t             beat,
  input  logic                                  beat_valid,
  output logic                                  beat_ready,
  // Beat result, no back-pressure
  output apb_bridge_pkg::beat_result_t          result,
  output logic                                  result_valid,
  // APB master pins
  output logic                                  PSEL,
  output logic                                  PENABLE,
  output logic [PADDR_WIDTH-1:0]                PADDR,
  output logic                                  PWRITE,
  output logic [2:0]                            PPROT,
  output logic [apb_bridge_pkg::PDATA_W-1:0]    PWDATA,
  output logic [apb_bridge_pkg::PSTRB_W-1:0]    PSTRB,
  input  logic [apb_bridge_pkg::PDATA_W-1:0]    PRDATA,
  input  logic                                  PREADY,
  input  logic                                  PSLVERR
);

  apb_bridge_pkg::apb_state_e state;

  assign beat_ready = (state == apb_bridge_pkg::APB_IDLE);

  // Result handed over on the edge that ends the access phase
  assign result_valid = (state == apb_bridge_pkg::APB_ACCESS) && PREADY;
  assign result       = '{prdata: PRDATA, pslverr: PSLVERR};

  //////////////////////////////////////////////////////////////////////
  // APB FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state   <= apb_bridge_pkg::APB_IDLE;
      PSEL    <= 1'b0;
      PENABLE <= 1'b0;
    end
    else
    begin
      case (state)
        apb_bridge_pkg::APB_IDLE:
        begin
          if (beat_valid)
          begin
            state <= apb_bridge_pkg::APB_SETUP;
            PSEL  <= 1'b1;
          end
        end

        apb_bridge_pkg::APB_SETUP:
        begin
          state   <= apb_bridge_pkg::APB_ACCESS;
          PENABLE <= 1'b1;
        end

        apb_bridge_pkg::APB_ACCESS:
        begin
          // PREADY low stretches the access phase
          if (PREADY)
          begin
            state   <= apb_bridge_pkg::APB_IDLE;
            PSEL    <= 1'b0;
            PENABLE <= 1'b0;
          end
        end

        default:
          state <= apb_bridge_pkg::APB_IDLE;
      endcase
    end
  end

  // Beat fields held on the pins for setup and access
  always_ff @(posedge HCLK)
  begin
    if (beat_valid && beat_ready)
    begin
      PADDR  <= beat.addr[PADDR_WIDTH-1:0];
      PWRITE <= beat.write;
      PPROT  <= beat.pprot;
      PWDATA <= beat.pwdata;
      PSTRB  <= beat.pstrb;
    end
  end

endmodule

/* verilog/ahb3lite_apb_bridge.sv */
// Top level of the synchronous AHB3-Lite to APB4 bridge
`timescale 1ns/1ns

module ahb3lite_apb_bridge #(
  parameter int PADDR_WIDTH = 10
)
(
  input  logic                                  HCLK,
  input  logic                                  HRESETn,
  // AHB3-Lite slave
  input  logic                                  HSEL,
  input  logic [apb_bridge_pkg::HADDR_W-1:0]    HADDR,
  input  logic [apb_bridge_pkg::HDATA_W-1:0]    HWDATA,
  output logic [apb_bridge_pkg::HDATA_W-1:0]    HRDATA,
  input  logic                                  HWRITE,
  input  logic [2:0]                            HSIZE,
  input  logic [3:0]                            HPROT,
  input  logic [1:0]                            HTRANS,
  output logic                                  HREADYOUT,
  input  logic                                  HREADY,
  output logic                                  HRESP,
  // APB4 master
  output logic                                  PSEL,
  output logic                                  PENABLE,
  output logic [2:0]                            PPROT,
  output logic                                  PWRITE,
  output logic [apb_bridge_pkg::PSTRB_W-1:0]    PSTRB,
  output logic [PADDR_WIDTH-1:0]                PADDR,
  output logic [apb_bridge_pkg::PDATA_W-1:0]    PWDATA,
  input  logic [apb_bridge_pkg::PDATA_W-1:0]    PRDATA,
  input  logic                                  PREADY,
  input  logic                                  PSLVERR
);

  //////////////////////////////////////////////////////////////////////
  // Internal handshakes
  //////////////////////////////////////////////////////////////////////

  // AHB port to sequencer
  apb_bridge_pkg::ahb_req_t     req;
  logic                         req_valid;
  logic                         req_ready;
  // Sequencer to APB port
  apb_bridge_pkg::apb_beat_t    beat;
  logic                         beat_valid;
  logic                         beat_ready;
  // APB port back to sequencer
  apb_bridge_pkg::beat_result_t result;
  logic                         result_valid;
  // Sequencer back to AHB port
  apb_bridge_pkg::ahb_rsp_t     rsp;
  logic                         rsp_valid;

  ahb_slave_port i_ahb_slave_port (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HTRANS    (HTRANS),
    .HPROT     (HPROT),
    .HREADY    (HREADY),
    .HWDATA    (HWDATA),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP),
    .HRDATA    (HRDATA),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid)
  );

  beat_sequencer i_beat_sequencer (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .req          (req),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .beat         (beat),
    .beat_valid   (beat_valid),
    .beat_ready   (beat_ready),
    .result       (result),
    .result_valid (result_valid),
    .rsp          (rsp),
    .rsp_valid    (rsp_valid)
  );

  // APB address width only matters on the pins
  apb_master_port #(
    .PADDR_WIDTH (PADDR_WIDTH)
  ) i_apb_master_port (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .beat         (beat),
    .beat_valid   (beat_valid),
    .beat_ready   (beat_ready),
    .result       (result),
    .result_valid (result_valid),
    .PSEL         (PSEL),
    .PENABLE      (PENABLE),
    .PADDR        (PADDR),
    .PWRITE       (PWRITE),
    .PPROT        (PPROT),
    .PWDATA       (PWDATA),
    .PSTRB        (PSTRB),
    .PRDATA       (PRDATA),
    .PREADY       (PREADY),
    .PSLVERR      (PSLVERR)
  );

endmodule

/* verification/tb_ahb3lite_apb_bridge.sv */
// Testbench for the AHB3-Lite to APB4 bridge with an AHB master driver and an APB slave model
`timescale 1ns/1ns

module tb_ahb3lite_apb_bridge;

  localparam int PADDR_WIDTH = 10;
  localparam int MAX_LINES   = 64;

  logic        HCLK;
  logic        HRESETn;
  logic        HSEL;
  logic [31:0] HADDR;
  logic [31:0] HWDATA;
  logic [31:0] HRDATA;
  logic        HWRITE;
  logic [2:0]  HSIZE;
  logic [3:0]  HPROT;
  logic [1:0]  HTRANS;
  logic        HREADYOUT;
  logic        HREADY;
  logic        HRESP;
  logic        PSEL;
  logic        PENABLE;
  logic [2:0]  PPROT;
  logic        PWRITE;
  logic [0:0]  PSTRB;
  logic [PADDR_WIDTH-1:0] PADDR;
  logic [7:0]  PWDATA;
  logic [7:0]  PRDATA;
  logic        PREADY;
  logic        PSLVERR;

  // Test table from the data file
  logic [8*24-1:0] t_name [MAX_LINES];
  logic [7:0]      t_op   [MAX_LINES];
  logic [2:0]      t_size [MAX_LINES];
  logic [31:0]     t_addr [MAX_LINES];
  logic [31:0]     t_wdat [MAX_LINES];
  logic [1:0]      t_prot [MAX_LINES];
  int              t_err  [MAX_LINES];
  logic [31:0]     t_rdat [MAX_LINES];
  logic            t_resp [MAX_LINES];
  int              n_lines;
  logic            loaded;

  // Current transfer as seen by the APB model
  logic [8*24-1:0] cur_name;
  logic            cur_write;
  logic [31:0]     cur_addr;
  logic [31:0]     cur_wdata;
  logic [1:0]      cur_prot;
  int              cur_err;
  int              beat_cnt;
  int              setup_cnt;

  logic [7:0]  mem     [1024];
  logic [7:0]  ref_mem [1024];
  logic [31:0] lfsr_state;
  logic [1:0]  wait_left;

  ahb3lite_apb_bridge #(
    .PADDR_WIDTH (PADDR_WIDTH)
  ) i_ahb3lite_apb_bridge (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HWDATA    (HWDATA),
    .HRDATA    (HRDATA),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HPROT     (HPROT),
    .HTRANS    (HTRANS),
    .HREADYOUT (HREADYOUT),
    .HREADY    (HREADY),
    .HRESP     (HRESP),
    .PSEL      (PSEL),
    .PENABLE   (PENABLE),
    .PPROT     (PPROT),
    .PWRITE    (PWRITE),
    .PSTRB     (PSTRB),
    .PADDR     (PADDR),
    .PWDATA    (PWDATA),
    .PRDATA    (PRDATA),
    .PREADY    (PREADY),
    .PSLVERR   (PSLVERR)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input logic [8*24-1:0] name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("[FAIL] %0s %0s: expected %h, actual %h", name, what, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Byte pattern over the full 10-bit address
  function automatic logic [7:0] fill_byte(input int a);
    logic [9:0] aa;
    aa = a[9:0];
    return aa[7:0] ^ {aa[9:8], 6'b0} ^ 8'h5A;
  endfunction

  // Privileged to bit 0, instruction fetch to bit 2
  function automatic logic [2:0] expected_pprot(input logic [1:0] hp);
    logic [2:0] p;
    p = 3'b000;
    if (hp[1])
      p[0] = 1'b1;
    if (!hp[0])
      p[2] = 1'b1;
    return p;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Clock, watchdog, APB slave model
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    HCLK = 1'b0;
    forever #5 HCLK = ~HCLK;
  end

  initial
  begin
    wait (loaded);
    repeat (40 * n_lines + 100) @(posedge HCLK);
    $display(">>> FAIL");
    $fatal(1, "Timeout: the transfers did not finish in the allowed time");
  end

  always @(posedge HCLK)
  begin
    #1;
    if (PSEL && !PENABLE)
    begin
      // Beat fields in the setup cycle
      check_value(cur_name, "PADDR", (cur_addr + beat_cnt) & 32'h3FF, 32'(PADDR));
      check_value(cur_name, "PWRITE", 32'(cur_write), 32'(PWRITE));
      check_value(cur_name, "PPROT", 32'(expected_pprot(cur_prot)), 32'(PPROT));
      check_value(cur_name, "PSTRB", 32'(cur_write), 32'(PSTRB));
      if (cur_write)
        check_value(cur_name, "PWDATA",
                    32'(cur_wdata[8*((cur_addr + beat_cnt) % 4) +: 8]), 32'(PWDATA));
      setup_cnt++;
      // Two random bits give 0 to 3 wait states
      lfsr_state   = lfsr_step(lfsr_state);
      wait_left[1] = lfsr_state[0];
      lfsr_state   = lfsr_step(lfsr_state);
      wait_left[0] = lfsr_state[0];
      PREADY  = 1'b0;
      PSLVERR = 1'b0;
    end
    else if (PSEL && PENABLE)
    begin
      if (wait_left == 2'd0)
      begin
        // Exactly one setup cycle per beat
        check_value(cur_name, "setup cycles", 32'(beat_cnt + 1), 32'(setup_cnt));
        PREADY  = 1'b1;
        PSLVERR = (beat_cnt == cur_err);
        PRDATA  = PWRITE ? 8'h00 : mem[PADDR];
        if (PWRITE && !PSLVERR)
          mem[PADDR] = PWDATA;
        beat_cnt++;
      end
      else
      begin
        PREADY    = 1'b0;
        wait_left = wait_left - 1'b1;
      end
    end
    else
    begin
      PREADY  = 1'b0;
      PSLVERR = 1'b0;
      PRDATA  = 8'h00;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // AHB master driver
  //////////////////////////////////////////////////////////////////////

  task automatic load_tests();
    int    fd;
    int    cnt;
    string line;
    logic [8*8-1:0] err_tok;
    fd      = $fopen("verification/bridge_input.txt", "r");
    n_lines = 0;
    if (fd == 0)
    begin
      $display(">>> FAIL");
      $fatal(1, "Could not open the stimulus file");
    end
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() < 4 || line.getc(0) == "#")
        continue;
      cnt = $sscanf(line, "%s %s %d %h %h %h %s %h %d", t_name[n_lines], t_op[n_lines],
                    t_size[n_lines], t_addr[n_lines], t_wdat[n_lines], t_prot[n_lines],
                    err_tok, t_rdat[n_lines], t_resp[n_lines]);
      if (cnt != 9)
      begin
        $display(">>> FAIL");
        $fatal(1, "Malformed line in the stimulus file");
      end
      t_err[n_lines] = -1;
      if (err_tok != "none")
        cnt = $sscanf(err_tok, "%d", t_err[n_lines]);
      n_lines++;
    end
    $fclose(fd);
  endtask

  // IDLE or BUSY gets a zero-wait OKAY and no APB beat
  task automatic idle_transfer(input int i);
    beat_cnt  = 0;
    setup_cnt = 0;
    cur_name  = t_name[i];
    @(posedge HCLK);
    #1;
    HSEL   = 1'b1;
    HTRANS = (t_op[i] == "B") ? 2'b01 : 2'b00;
    HADDR  = t_addr[i];
    @(posedge HCLK);
    #1;
    HSEL = 1'b0;
    @(negedge HCLK);
    check_value(cur_name, "HREADYOUT", 32'd1, 32'(HREADYOUT));
    check_value(cur_name, "HRESP", 32'd0, 32'(HRESP));
    repeat (3) @(posedge HCLK);
    check_value(cur_name, "setup cycles", 32'd0, 32'(setup_cnt));
    check_value(cur_name, "beat count", 32'd0, 32'(beat_cnt));
  endtask

  task automatic data_transfer(input int i);
    int   err_low;
    logic done;
    logic resp;
    logic [31:0] rdata;
    int   n_bytes;
    int   exp_beats;
    int   a;
    cur_name  = t_name[i];
    cur_write = (t_op[i] == "W");
    cur_addr  = t_addr[i];
    cur_wdata = t_wdat[i];
    cur_prot  = t_prot[i];
    cur_err   = t_err[i];
    beat_cnt  = 0;
    setup_cnt = 0;
    n_bytes   = 1 << t_size[i];
    // Address phase
    @(posedge HCLK);
    #1;
    HSEL   = 1'b1;
    HTRANS = 2'b10;
    HADDR  = t_addr[i];
    HWRITE = cur_write;
    HSIZE  = t_size[i];
    HPROT  = {2'b00, t_prot[i]};
    // Data phase
    @(posedge HCLK);
    #1;
    HSEL   = 1'b0;
    HTRANS = 2'b00;
    HWDATA = t_wdat[i];
    err_low = 0;
    done    = 1'b0;
    while (!done)
    begin
      @(negedge HCLK);
      if (HREADYOUT)
        done = 1'b1;
      else if (HRESP)
        err_low++;
    end
    resp  = HRESP;
    rdata = HRDATA;
    check_value(cur_name, "HRESP", 32'(t_resp[i]), 32'(resp));
    // ERROR has exactly one cycle with HREADYOUT low
    check_value(cur_name, "first error cycle", 32'(t_resp[i]), 32'(err_low));
    if (!cur_write && !t_resp[i])
      check_value(cur_name, "HRDATA", t_rdat[i], rdata);
    exp_beats = (cur_err >= 0) ? cur_err + 1 : n_bytes;
    check_value(cur_name, "beat count", 32'(exp_beats), 32'(beat_cnt));
    check_value(cur_name, "setup cycles", 32'(exp_beats), 32'(setup_cnt));
    if (cur_write)
    begin
      for (int k = 0; k < n_bytes; k++)
      begin
        a = (cur_addr + k) % 1024;
        if (cur_err < 0 || k < cur_err)
          ref_mem[a] = cur_wdata[8*((cur_addr + k) % 4) +: 8];
        check_value(cur_name, "memory byte", 32'(ref_mem[a]), 32'(mem[a]));
      end
    end
    @(posedge HCLK);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    loaded     = 1'b0;
    lfsr_state = 32'hcccf376c;
    wait_left  = 2'd0;
    beat_cnt   = 0;
    setup_cnt  = 0;
    cur_err    = -1;
    HRESETn = 1'b0;
    HSEL    = 1'b0;
    HADDR   = '0;
    HWDATA  = '0;
    HWRITE  = 1'b0;
    HSIZE   = 3'b000;
    HPROT   = 4'b0011;
    HTRANS  = 2'b00;
    HREADY  = 1'b1;
    PRDATA  = 8'h00;
    PREADY  = 1'b0;
    PSLVERR = 1'b0;
    for (int a = 0; a < 1024; a++)
    begin
      mem[a]     = fill_byte(a);
      ref_mem[a] = fill_byte(a);
    end
    load_tests();
    loaded = 1'b1;
    repeat (4) @(posedge HCLK);
    #1;
    HRESETn = 1'b1;
    for (int i = 0; i < n_lines; i++)
    begin
      if (t_op[i] == "I" || t_op[i] == "B")
        idle_transfer(i);
      else
        data_transfer(i);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

/* verification/bridge_input.txt */
# name op(W/R/I/B) hsize haddr hwdata hprot err_beat(none|n) exp_hrdata exp_hresp
# Memory preload: byte = a[7:0] ^ {a[9:8],6'b0} ^ 8'h5A
rd_byte_lane0     R 0 00000010 00000000 3 none 0000004A 0
rd_byte_lane3     R 0 00000013 00000000 2 none 49000000 0
rd_hword_upper    R 1 00000022 00000000 1 none 79780000 0
rd_word           R 2 00000040 00000000 0 none 19181B1A 0
wr_byte           W 0 00000081 0000AB00 3 none 00000000 0
rd_after_wr_byte  R 0 00000081 00000000 3 none 0000AB00 0
wr_hword          W 1 00000092 BEEF0000 2 none 00000000 0
rd_after_wr_hword R 1 00000092 00000000 2 none BEEF0000 0
wr_word           W 2 000000A0 12345678 1 none 00000000 0
rd_after_wr_word  R 2 000000A0 00000000 1 none 12345678 0
idle_cycle        I 0 00000000 00000000 3 none 00000000 0
wr_word_err       W 2 000000B0 CAFEF00D 0 2    00000000 1
rd_after_err      R 2 000000B0 00000000 3 none E9E8F00D 0
rd_byte_err       R 0 00000005 00000000 3 0    00000000 1
busy_cycle        B 0 00000000 00000000 3 none 00000000 0
rd_hword_high     R 1 00000306 00000000 3 none 9D9C0000 0
wr_word_high      W 2 000002FC 00C0FFEE 3 none 00000000 0
rd_word_high      R 2 000002FC 00000000 0 none 00C0FFEE 0

/* all.f */
verilog/apb_bridge_pkg.sv
verilog/ahb_slave_port.sv
verilog/beat_sequencer.sv
verilog/apb_master_port.sv
verilog/ahb3lite_apb_bridge.sv
verification/tb_ahb3lite_apb_bridge.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ahb3lite_apb_bridge
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
